/* design/smc_lite_pkg.sv */
// Static memory controller lite, shared definitions
// Register layout, bus widths and strobe FSM states

package smc_lite_pkg;

  // --------------------
  // Bus widths
  localparam int APB_ADDR_W = 5;   // APB offset bits
  localparam int DATA_W     = 32;  // APB and memory data
  localparam int MEM_ADDR_W = 16;  // External word address

  // --------------------
  // Config register
  localparam logic [APB_ADDR_W-1:0] ADDR_CONFIG0 = 5'h00;

  localparam int RD_WAIT_LSB = 0;  // Read wait field
  localparam int WR_WAIT_LSB = 4;  // Write wait field
  localparam int WAIT_W      = 4;
  localparam int HOLD_BIT    = 8;  // Set for two-cycle hold

  // Read wait 1, write wait 1
  localparam logic [DATA_W-1:0] CFG_RESET     = 32'h0000_0011;
  localparam logic [DATA_W-1:0] CFG_USED_MASK = 32'h0000_01FF;  // Stored bits

  // --------------------
  // Strobe timing FSM
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // Waiting for buffered request
    ST_SETUP  = 2'd1,  // cs only
    ST_ACCESS = 2'd2,  // oe or we active
    ST_HOLD   = 2'd3   // cs only, strobes released
  } smc_state_e;

endpackage

/* design/smc_cfreg_lite.sv */
// Timing configuration register of the memory controller
// Holds the read and write wait states and the hold length
`timescale 1ns/100ps

module smc_cfreg_lite (
  input  logic                             pclk,
  input  logic                             rst_n,
  input  logic                             selreg,   // Decoded APB access
  input  logic                             pwrite,
  input  logic [smc_lite_pkg::DATA_W-1:0]  pwdata,
  output logic [smc_lite_pkg::DATA_W-1:0]  rdata,    // Zero when not selected
  output logic [smc_lite_pkg::WAIT_W-1:0]  rd_wait,
  output logic [smc_lite_pkg::WAIT_W-1:0]  wr_wait,
  output logic                             hold_long
);

  logic [smc_lite_pkg::DATA_W-1:0] cfg_q;  // Unused bits stay zero

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      cfg_q <= smc_lite_pkg::CFG_RESET;
    else if (selreg && pwrite)
      cfg_q <= pwdata & smc_lite_pkg::CFG_USED_MASK;
  end

  // Gated readback so the interface mux is a plain OR
  assign rdata = selreg ? (cfg_q & smc_lite_pkg::CFG_USED_MASK) : '0;

  // Field extraction
  assign rd_wait   = cfg_q[smc_lite_pkg::RD_WAIT_LSB +: smc_lite_pkg::WAIT_W];
  assign wr_wait   = cfg_q[smc_lite_pkg::WR_WAIT_LSB +: smc_lite_pkg::WAIT_W];
  assign hold_long = cfg_q[smc_lite_pkg::HOLD_BIT];

endmodule

/* design/smc_apb_lite_if.sv */
// APB slave interface of the memory controller
// Decodes the register select and muxes read data
`timescale 1ns/100ps

module smc_apb_lite_if (
  input  logic                                pclk,
  input  logic                                rst_n,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [smc_lite_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     pwdata,
  output logic [smc_lite_pkg::DATA_W-1:0]     prdata,
  output logic [smc_lite_pkg::WAIT_W-1:0]     rd_wait,
  output logic [smc_lite_pkg::WAIT_W-1:0]     wr_wait,
  output logic                                hold_long
);

  logic                            selreg;  // Config register 0 selected
  logic [smc_lite_pkg::DATA_W-1:0] rdata0;  // Gated readback of register 0

  // --------------------
  // Address decode, access phase only
  always_comb
  begin
    selreg = 1'b0;
    if (psel && penable)
    begin
      if (paddr == smc_lite_pkg::ADDR_CONFIG0)
        selreg = 1'b1;
    end
  end

  smc_cfreg_lite i_cfreg0 (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .selreg    (selreg),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .rdata     (rdata0),
    .rd_wait   (rd_wait),
    .wr_wait   (wr_wait),
    .hold_long (hold_long)
  );

  // One register, so the OR mux collapses to it
  assign prdata = rdata0;

endmodule

/* design/smc_req_buffer.sv */
// Stage 1, one-entry host request buffer
// Holds the next access while the strobe FSM is busy
`timescale 1ns/100ps

module smc_req_buffer (
  input  logic                                pclk,
  input  logic                                rst_n,
  input  logic                                req,        // One-cycle host pulse
  input  logic                                we,
  input  logic [smc_lite_pkg::MEM_ADDR_W-1:0] addr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     wdata,
  input  logic                                take,       // FSM accepts entry
  output logic                                ready,
  output logic                                buf_valid,
  output logic                                buf_we,
  output logic [smc_lite_pkg::MEM_ADDR_W-1:0] buf_addr,
  output logic [smc_lite_pkg::DATA_W-1:0]     buf_wdata
);

  logic load;  // Accept a host request

  assign load  = req && !buf_valid;  // req while full is dropped
  assign ready = !buf_valid;

  // Valid flag
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      buf_valid <= 1'b0;
    else if (load)
      buf_valid <= 1'b1;
    else if (take)
      buf_valid <= 1'b0;  // Freed as the FSM starts the access
  end

  // Request payload latched on load
  always_ff @(posedge pclk)
  begin
    if (load)
    begin
      buf_we    <= we;
      buf_addr  <= addr;
      buf_wdata <= wdata;
    end
  end

endmodule

/* design/smc_strobe_fsm.sv */
// Stage 2, strobe timing FSM
// Setup, access and hold phases with programmed wait states
`timescale 1ns/100ps

module smc_strobe_fsm (
  input  logic                                pclk,
  input  logic                                rst_n,
  input  logic                                buf_valid,
  input  logic                                buf_we,
  input  logic [smc_lite_pkg::MEM_ADDR_W-1:0] buf_addr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     buf_wdata,
  input  logic [smc_lite_pkg::WAIT_W-1:0]     rd_wait,
  input  logic [smc_lite_pkg::WAIT_W-1:0]     wr_wait,
  input  logic                                hold_long,
  output logic                                take,      // Leaving ST_IDLE
  output logic                                cs_act,
  output logic                                oe_act,
  output logic                                we_act,
  output logic                                acc_we,
  output logic [smc_lite_pkg::MEM_ADDR_W-1:0] acc_addr,
  output logic [smc_lite_pkg::DATA_W-1:0]     acc_wdata,
  output logic                                last       // Final hold cycle
);

  smc_lite_pkg::smc_state_e state_q;
  logic [smc_lite_pkg::WAIT_W-1:0] cnt_q;   // Phase down-counter
  logic                            hold_q;  // Hold length latched at take

  assign take = (state_q == smc_lite_pkg::ST_IDLE) && buf_valid;

  // --------------------
  // State and counter
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      state_q <= smc_lite_pkg::ST_IDLE;
      cnt_q   <= '0;
      hold_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        smc_lite_pkg::ST_IDLE:
        begin
          if (take)
          begin
            state_q <= smc_lite_pkg::ST_SETUP;
            cnt_q   <= buf_we ? wr_wait : rd_wait;  // Config sampled here
            hold_q  <= hold_long;
          end
        end
        smc_lite_pkg::ST_SETUP:
          state_q <= smc_lite_pkg::ST_ACCESS;  // Always one cycle
        smc_lite_pkg::ST_ACCESS:
        begin
          // wait + 1 cycles in this phase
          if (cnt_q == '0)
          begin
            state_q <= smc_lite_pkg::ST_HOLD;
            cnt_q   <= {{(smc_lite_pkg::WAIT_W-1){1'b0}}, hold_q};
          end
          else
            cnt_q <= cnt_q - 1'b1;
        end
        smc_lite_pkg::ST_HOLD:
        begin
          if (cnt_q == '0)
            state_q <= smc_lite_pkg::ST_IDLE;
          else
            cnt_q <= cnt_q - 1'b1;  // Second hold cycle
        end
        default:
          state_q <= smc_lite_pkg::ST_IDLE;
      endcase
    end
  end

  // Access payload, held until the next take
  always_ff @(posedge pclk)
  begin
    if (take)
    begin
      acc_we    <= buf_we;
      acc_addr  <= buf_addr;
      acc_wdata <= buf_wdata;
    end
  end

  // --------------------
  // Strobe decode
  assign cs_act = (state_q != smc_lite_pkg::ST_IDLE);
  assign oe_act = (state_q == smc_lite_pkg::ST_ACCESS) && !acc_we;
  assign we_act = (state_q == smc_lite_pkg::ST_ACCESS) && acc_we;
  assign last   = (state_q == smc_lite_pkg::ST_HOLD) && (cnt_q == '0);

endmodule

/* design/smc_mem_port.sv */
// Stage 3, external memory pin stage
// Registered active-low strobes, read capture and done pulse
`timescale 1ns/100ps

module smc_mem_port (
  input  logic                                pclk,
  input  logic                                rst_n,
  input  logic                                cs_act,
  input  logic                                oe_act,
  input  logic                                we_act,
  input  logic                                acc_we,
  input  logic                                last,
  input  logic [smc_lite_pkg::MEM_ADDR_W-1:0] acc_addr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     acc_wdata,
  input  logic [smc_lite_pkg::DATA_W-1:0]     mem_din,
  output logic                                mem_cs_n,
  output logic                                mem_oe_n,
  output logic                                mem_we_n,
  output logic [smc_lite_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [smc_lite_pkg::DATA_W-1:0]     mem_dout,
  output logic [smc_lite_pkg::DATA_W-1:0]     rdata,
  output logic                                done
);

  logic rd_capture;  // Edge where mem_oe_n rises

  // Pin oe still low but FSM has left ST_ACCESS
  assign rd_capture = !mem_oe_n && !oe_act && !acc_we;

  // --------------------
  // Control pins, one cycle behind the FSM
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      mem_cs_n <= 1'b1;
      mem_oe_n <= 1'b1;
      mem_we_n <= 1'b1;
      done     <= 1'b0;
    end
    else
    begin
      mem_cs_n <= !cs_act;
      mem_oe_n <= !oe_act;
      mem_we_n <= !we_act;
      done     <= last;  // One cycle after the final hold
    end
  end

  // Address, write data and read capture
  always_ff @(posedge pclk)
  begin
    mem_addr <= acc_addr;
    mem_dout <= acc_wdata;
    if (rd_capture)
      rdata <= mem_din;
  end

endmodule

/* design/smc_lite.sv */
// Lite static memory controller top level
// APB config port plus request buffer, strobe FSM and pin stage
`timescale 1ns/100ps

module smc_lite (
  input  logic                                pclk,
  input  logic                                rst_n,
  // APB
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [smc_lite_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     pwdata,
  output logic [smc_lite_pkg::DATA_W-1:0]     prdata,
  // Host
  input  logic                                req,
  input  logic                                we,
  input  logic [smc_lite_pkg::MEM_ADDR_W-1:0] addr,
  input  logic [smc_lite_pkg::DATA_W-1:0]     wdata,
  output logic                                ready,
  output logic [smc_lite_pkg::DATA_W-1:0]     rdata,
  output logic                                done,
  // External memory
  output logic                                mem_cs_n,
  output logic                                mem_oe_n,
  output logic                                mem_we_n,
  output logic [smc_lite_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [smc_lite_pkg::DATA_W-1:0]     mem_dout,
  input  logic [smc_lite_pkg::DATA_W-1:0]     mem_din
);

  // --------------------
  // Internal nets
  logic [smc_lite_pkg::WAIT_W-1:0]     rd_wait;
  logic [smc_lite_pkg::WAIT_W-1:0]     wr_wait;
  logic                                hold_long;
  logic                                take;
  logic                                buf_valid;
  logic                                buf_we;
  logic [smc_lite_pkg::MEM_ADDR_W-1:0] buf_addr;
  logic [smc_lite_pkg::DATA_W-1:0]     buf_wdata;
  logic                                cs_act;
  logic                                oe_act;
  logic                                we_act;
  logic                                acc_we;
  logic [smc_lite_pkg::MEM_ADDR_W-1:0] acc_addr;
  logic [smc_lite_pkg::DATA_W-1:0]     acc_wdata;
  logic                                last;

  smc_apb_lite_if i_apb_if (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .rd_wait   (rd_wait),
    .wr_wait   (wr_wait),
    .hold_long (hold_long)
  );

  // Stage 1
  smc_req_buffer i_req_buffer (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .take      (take),
    .ready     (ready),
    .buf_valid (buf_valid),
    .buf_we    (buf_we),
    .buf_addr  (buf_addr),
    .buf_wdata (buf_wdata)
  );

  // Stage 2
  smc_strobe_fsm i_strobe_fsm (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .buf_valid (buf_valid),
    .buf_we    (buf_we),
    .buf_addr  (buf_addr),
    .buf_wdata (buf_wdata),
    .rd_wait   (rd_wait),
    .wr_wait   (wr_wait),
    .hold_long (hold_long),
    .take      (take),
    .cs_act    (cs_act),
    .oe_act    (oe_act),
    .we_act    (we_act),
    .acc_we    (acc_we),
    .acc_addr  (acc_addr),
    .acc_wdata (acc_wdata),
    .last      (last)
  );

  // Stage 3
  smc_mem_port i_mem_port (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .cs_act    (cs_act),
    .oe_act    (oe_act),
    .we_act    (we_act),
    .acc_we    (acc_we),
    .last      (last),
    .acc_addr  (acc_addr),
    .acc_wdata (acc_wdata),
    .mem_din   (mem_din),
    .mem_cs_n  (mem_cs_n),
    .mem_oe_n  (mem_oe_n),
    .mem_we_n  (mem_we_n),
    .mem_addr  (mem_addr),
    .mem_dout  (mem_dout),
    .rdata     (rdata),
    .done      (done)
  );

endmodule

/* tests/smc_lite_clkgen.sv */
// Testbench clock and reset generator
// 8 ns pclk, synchronous reset held low for three cycles
`timescale 1ns/100ps

module smc_lite_clkgen (
  output logic pclk,
  output logic rst_n
);

  initial
  begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;  // 8 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge pclk);
    rst_n <= 1'b1;  // Released on the third edge
  end

endmodule

/* tests/smc_lite_checker.sv */
// Strobe assertions for the memory controller FSM
// Bound into every smc_strobe_fsm instance
`timescale 1ns/100ps

module smc_lite_checker (
  input logic                     pclk,
  input logic                     rst_n,
  input smc_lite_pkg::smc_state_e state,
  input logic                     take,
  input logic                     buf_valid,
  input logic                     cs_act,
  input logic                     oe_act,
  input logic                     we_act
);

  // --------------------
  // Strobe rules
  a_oe_we_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    !(oe_act && we_act))
    else $error("oe_act and we_act high together");

  a_strobe_cs: assert property (@(posedge pclk) disable iff (!rst_n)
    (oe_act || we_act) |-> cs_act)
    else $error("oe_act or we_act high without cs_act");

  // Buffer handover
  a_take_idle: assert property (@(posedge pclk) disable iff (!rst_n)
    take |-> (state == smc_lite_pkg::ST_IDLE) && buf_valid)
    else $error("take outside ST_IDLE or with an empty buffer");

endmodule

bind smc_strobe_fsm smc_lite_checker checker_inst (
  .pclk      (pclk),
  .rst_n     (rst_n),
  .state     (state_q),
  .take      (take),
  .buf_valid (buf_valid),
  .cs_act    (cs_act),
  .oe_act    (oe_act),
  .we_act    (we_act)
);

/* tests/smc_lite_tb.sv */
// Testbench for the lite static memory controller
// SRAM model, table of APB and host steps, back-to-back LCG traffic
`timescale 1ns/100ps

module smc_lite_tb;

  localparam int TIMEOUT_CYC = 64;  // Per wait loop
  localparam int NSTEPS      = 15;

  typedef enum logic [2:0] {
    K_APB_WR,
    K_APB_RD,
    K_HOST_WR,
    K_HOST_RD,
    K_HOST_RD_MID  // Host read with a config write during the access
  } step_kind_e;

  typedef struct packed {
    step_kind_e  kind;
    logic [15:0] addr;
    logic [31:0] data;  // Write data, or new config for K_HOST_RD_MID
    logic [31:0] exp;   // Expected read data
  } step_t;

  logic                                pclk;
  logic                                rst_n;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [smc_lite_pkg::APB_ADDR_W-1:0] paddr;
  logic [smc_lite_pkg::DATA_W-1:0]     pwdata;
  logic [smc_lite_pkg::DATA_W-1:0]     prdata;
  logic                                req;
  logic                                we;
  logic [smc_lite_pkg::MEM_ADDR_W-1:0] addr;
  logic [smc_lite_pkg::DATA_W-1:0]     wdata;
  logic                                ready;
  logic [smc_lite_pkg::DATA_W-1:0]     rdata;
  logic                                done;
  logic                                mem_cs_n;
  logic                                mem_oe_n;
  logic                                mem_we_n;
  logic [smc_lite_pkg::MEM_ADDR_W-1:0] mem_addr;
  logic [smc_lite_pkg::DATA_W-1:0]     mem_dout;
  logic [smc_lite_pkg::DATA_W-1:0]     mem_din;

  logic [31:0] sram    [0:63];  // External SRAM model
  logic [31:0] ref_mem [0:63];  // Expected SRAM contents
  step_t       steps   [0:NSTEPS-1];
  logic [31:0] cfg_model;       // Expected config register
  logic [31:0] lcg_state;
  bit          saw_backpressure;
  int          step_idx;
  bit          exp_is_read [$];
  logic [31:0] exp_data    [$];

  smc_lite_clkgen i_clkgen (
    .pclk  (pclk),
    .rst_n (rst_n)
  );

  smc_lite smc_lite_inst (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .ready    (ready),
    .rdata    (rdata),
    .done     (done),
    .mem_cs_n (mem_cs_n),
    .mem_oe_n (mem_oe_n),
    .mem_we_n (mem_we_n),
    .mem_addr (mem_addr),
    .mem_dout (mem_dout),
    .mem_din  (mem_din)
  );

  // --------------------
  // SRAM model, 64 words
  assign mem_din = !mem_oe_n ? sram[mem_addr[5:0]] : '0;

  always @(posedge mem_we_n)
  begin
    if (rst_n && !mem_cs_n)
      sram[mem_addr[5:0]] <= mem_dout;  // Write on rising we_n
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Initial SRAM contents, whole address in the word
  function automatic logic [31:0] fill_word(input int i);
    return {16'hc0de, 4'h0, 6'(i), ~6'(i)};
  endfunction

  // --------------------
  // Failure and compare tasks
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name,
                            input logic [smc_lite_pkg::DATA_W-1:0] got,
                            input logic [smc_lite_pkg::DATA_W-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h (step %0d)",
                                  name, got, exp, step_idx));
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp)
      stop_with_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h (step %0d)",
                                  name, got, exp, step_idx));
  endtask

  // --------------------
  // Wait loops
  task automatic wait_reset();
    int n;
    n = 0;
    @(negedge pclk);
    while (!rst_n && n < TIMEOUT_CYC)
    begin
      @(negedge pclk);
      n++;
    end
    if (!rst_n)
      stop_with_failure("Reset was not released within 64 cycles");
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge pclk);
    while (!ready && n < TIMEOUT_CYC)
    begin
      if (!mem_cs_n)
        saw_backpressure = 1'b1;  // Buffered entry behind an active access
      @(negedge pclk);
      n++;
    end
    if (!ready)
      stop_with_failure("ready stayed low for 64 cycles");
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge pclk);
    while (!done && n < TIMEOUT_CYC)
    begin
      @(negedge pclk);
      n++;
    end
    if (!done)
      stop_with_failure("No done pulse within 64 cycles in back-to-back traffic");
  endtask

  // --------------------
  // APB accesses, setup then access phase
  task automatic apb_write(input logic [4:0] a, input logic [31:0] d);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);  // Register written at this edge
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] a, output logic [31:0] rd);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    rd = prdata;  // Combinational in the access phase
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // One host access, counts cycles to done and strobe-low cycles
  task automatic host_access(input logic is_wr, input logic [15:0] a, input logic [31:0] d,
                             input bit mid_cfg, output int lat, output int strobes,
                             output logic [31:0] rd);
    bit seen;
    seen    = 1'b0;
    lat     = 0;
    strobes = 0;
    rd      = '0;
    wait_ready();
    @(posedge pclk);
    req   <= 1'b1;
    we    <= is_wr;
    addr  <= a;
    wdata <= d;
    fork
      begin
        while (!seen && lat < TIMEOUT_CYC)
        begin
          @(posedge pclk);
          req <= 1'b0;  // One-cycle pulse
          @(negedge pclk);
          lat++;
          if (!mem_oe_n || !mem_we_n)
            strobes++;
          if (done)
          begin
            seen = 1'b1;
            rd   = rdata;
          end
        end
      end
      begin
        // Config change after the FSM sampled it
        if (mid_cfg)
        begin
          repeat (2) @(posedge pclk);
          apb_write(5'h00, d);
        end
      end
    join
    if (!seen)
      stop_with_failure("No done pulse within 64 cycles of a host request");
  endtask

  // --------------------
  // Stimulus table
  task automatic load_steps();
    steps[0]  = '{K_APB_RD,      16'h0000, 32'h0000_0000, 32'h0000_0011};
    steps[1]  = '{K_APB_RD,      16'h0004, 32'h0000_0000, 32'h0000_0000};
    steps[2]  = '{K_APB_RD,      16'h001c, 32'h0000_0000, 32'h0000_0000};
    steps[3]  = '{K_APB_WR,      16'h0000, 32'hffff_ffff, 32'h0000_0000};
    steps[4]  = '{K_APB_RD,      16'h0000, 32'h0000_0000, 32'h0000_01ff};
    steps[5]  = '{K_HOST_RD,     16'h0003, 32'h0000_0000, fill_word(3)};   // Wait 15, long hold
    steps[6]  = '{K_APB_WR,      16'h0000, 32'h0000_0020, 32'h0000_0000};
    steps[7]  = '{K_HOST_WR,     16'h000a, 32'h1234_5678, 32'h0000_0000};  // Write wait 2
    steps[8]  = '{K_HOST_RD,     16'h000a, 32'h0000_0000, 32'h1234_5678};  // Read wait 0
    steps[9]  = '{K_APB_WR,      16'h0000, 32'h0000_0123, 32'h0000_0000};
    steps[10] = '{K_HOST_RD,     16'h000a, 32'h0000_0000, 32'h1234_5678};  // Read wait 3
    steps[11] = '{K_HOST_WR,     16'h0014, 32'hcafe_f00d, 32'h0000_0000};
    steps[12] = '{K_HOST_RD_MID, 16'h0014, 32'h0000_000f, 32'hcafe_f00d};
    steps[13] = '{K_HOST_RD,     16'h0014, 32'h0000_0000, 32'hcafe_f00d};  // New timing
    steps[14] = '{K_APB_WR,      16'h0000, 32'h0000_0010, 32'h0000_0000};
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rd;
    int          lat;
    int          strobes;
    int          wait_cyc;
    int          hold_cyc;
    logic        is_wr;
    case (s.kind)
      K_APB_WR:
      begin
        apb_write(s.addr[4:0], s.data);
        if (s.addr[4:0] == 5'h00)
          cfg_model = s.data & 32'h0000_01ff;
      end
      K_APB_RD:
      begin
        apb_read(s.addr[4:0], rd);
        check_word("prdata", rd, s.exp);
      end
      default:
      begin
        is_wr    = (s.kind == K_HOST_WR);
        wait_cyc = is_wr ? int'(cfg_model[7:4]) : int'(cfg_model[3:0]);
        hold_cyc = cfg_model[8] ? 2 : 1;
        host_access(is_wr, s.addr, s.data, s.kind == K_HOST_RD_MID, lat, strobes, rd);
        check_latency("req_to_done", lat, wait_cyc + hold_cyc + 4);
        check_latency("strobe_low_cycles", strobes, wait_cyc + 1);
        if (is_wr)
        begin
          check_word("sram", sram[s.addr[5:0]], s.data);
          ref_mem[s.addr[5:0]] = s.data;
        end
        else
          check_word("rdata", rd, s.exp);
        if (s.kind == K_HOST_RD_MID)
          cfg_model = s.data & 32'h0000_01ff;  // Applies from the next access
      end
    endcase
  endtask

  // --------------------
  // Back-to-back writes then reads
  task automatic run_back_to_back();
    logic [15:0] b_addr [0:7];
    logic [31:0] b_data [0:7];
    for (int i = 0; i < 8; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      b_addr[i] = {12'h000, lcg_state[19:16]};  // 16 words, repeats likely
      lcg_state = lcg_next(lcg_state);
      b_data[i] = lcg_state;
    end
    saw_backpressure = 1'b0;
    fork
      begin
        for (int n = 0; n < 16; n++)
        begin
          wait_ready();
          if (n < 8)
          begin
            ref_mem[b_addr[n][5:0]] = b_data[n];
            exp_is_read.push_back(1'b0);
            exp_data.push_back('0);
          end
          else
          begin
            exp_is_read.push_back(1'b1);
            exp_data.push_back(ref_mem[b_addr[n-8][5:0]]);
          end
          @(posedge pclk);
          req   <= 1'b1;
          we    <= (n < 8);
          addr  <= b_addr[n%8];
          wdata <= b_data[n%8];
          @(posedge pclk);
          req   <= 1'b0;
        end
      end
      begin
        // Completions arrive in issue order
        for (int n = 0; n < 16; n++)
        begin
          wait_done();
          if (exp_is_read.pop_front())
            check_word("rdata_b2b", rdata, exp_data.pop_front());
          else
            void'(exp_data.pop_front());
        end
      end
    join
    if (!saw_backpressure)
      stop_with_failure("ready was never low while an access was buffered behind another");
  endtask

  // --------------------
  // Main sequence
  initial
  begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    lcg_state = 32'h5e08_31ae;
    cfg_model = 32'h0000_0011;  // Reset timing
    step_idx  = 0;
    saw_backpressure = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      sram[i]    = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    load_steps();
    wait_reset();
    // cs_n, oe_n, we_n high, ready high, done low
    check_word("pins_after_reset", {27'h0, mem_cs_n, mem_oe_n, mem_we_n, ready, done},
               32'h0000_001e);
    for (int i = 0; i < NSTEPS; i++)
    begin
      step_idx = i;
      run_step(steps[i]);
    end
    step_idx = NSTEPS;
    run_back_to_back();
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* smc_lite.f */
design/smc_lite_pkg.sv
design/smc_cfreg_lite.sv
design/smc_apb_lite_if.sv
design/smc_req_buffer.sv
design/smc_strobe_fsm.sv
design/smc_mem_port.sv
design/smc_lite.sv
tests/smc_lite_clkgen.sv
tests/smc_lite_checker.sv
tests/smc_lite_tb.sv

/* Bender.yml */
package:
  name: smc_lite

sources:
  - design/smc_lite_pkg.sv
  - design/smc_cfreg_lite.sv
  - design/smc_apb_lite_if.sv
  - design/smc_req_buffer.sv
  - design/smc_strobe_fsm.sv
  - design/smc_mem_port.sv
  - design/smc_lite.sv
  - target: test
    files:
      - tests/smc_lite_clkgen.sv
      - tests/smc_lite_checker.sv
      - tests/smc_lite_tb.sv
